//--- include/rv_map.svh
`ifndef RV_MAP_SVH
`define RV_MAP_SVH

// memory map, byte addresses

// program and data ram, first fetch lands here
`define RAM_BASE 64'h0000_0000_0000_1000

// key peripheral, read side
`define KEY_BASE 64'h0000_0000_1000_0000

// art peripheral, write side
`define ART_BASE 64'h0000_0000_1000_1000

`endif

//--- hdl/rv_pkg.sv
package rv_pkg;

`include "rv_map.svh"

    // widths
    localparam int XLEN  = 64;             // register / data width
    localparam int ILEN  = 32;             // instruction word
    localparam int NREGS = 32;             // x0..x31
    localparam int RAW   = $clog2(NREGS);  // register index width

    // vectors
    localparam logic [XLEN-1:0] RESET_PC = `RAM_BASE;
    localparam logic [XLEN-1:0] TRAP_VEC = `RAM_BASE + 64'h200;  // fixed handler

    // major opcodes, instr[6:0]
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    // minor fields
    localparam logic [2:0]  F3_ADD   = 3'b000;   // addi / add
    localparam logic [2:0]  F3_DW    = 3'b011;   // ld / sd
    localparam logic [6:0]  F7_ADD   = 7'b0000000;
    localparam logic [11:0] F12_MRET = 12'h302;

    // what execute does with a decoded word
    typedef enum logic [2:0] {
        K_ALU_IMM,
        K_ALU_REG,
        K_LUI,
        K_LOAD,
        K_STORE,
        K_MRET
    } kind_t;

    // decode register contents
    typedef struct packed {
        logic            valid;
        kind_t           kind;
        logic [RAW-1:0]  rd;
        logic [RAW-1:0]  rs1;
        logic [RAW-1:0]  rs2;
        logic [XLEN-1:0] imm;   // already sign extended
        logic [XLEN-1:0] pc;
    } dec_t;

    // one peripheral bus request
    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
        logic            write;  // 0 = read
        logic            valid;
    } bus_req_t;

    // read response
    typedef struct packed {
        logic [XLEN-1:0] rdata;
        logic            valid;
    } bus_rsp_t;

    // retire record
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [RAW-1:0]  rd;     // zero when nothing written
        logic [XLEN-1:0] value;
    } retire_t;

endpackage

//--- hdl/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    stall,
    input  logic                    redirect,
    input  logic [rv_pkg::XLEN-1:0] redirect_pc,
    input  logic [rv_pkg::ILEN-1:0] instr,
    output logic [rv_pkg::XLEN-1:0] pc,
    output rv_pkg::dec_t            dec
);
    import rv_pkg::*;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_u;
    dec_t            dec_next;

    // field split of the word coming back for pc
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // immediate formats
    assign imm_i = {{(XLEN-12){instr[31]}}, instr[31:20]};
    assign imm_s = {{(XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_u = {{(XLEN-32){instr[31]}}, instr[31:12], 12'b0};  // lui sign extends on rv64

    // decode, anything outside the subset stays invalid
    always_comb begin
        dec_next     = '0;
        dec_next.pc  = pc;
        dec_next.rd  = instr[11:7];
        dec_next.rs1 = instr[19:15];
        dec_next.rs2 = instr[24:20];
        case (opcode)
            OP_LUI: begin
                dec_next.valid = 1'b1;
                dec_next.kind  = K_LUI;
                dec_next.imm   = imm_u;
            end
            OP_IMM: begin
                dec_next.valid = (funct3 == F3_ADD);     // addi only
                dec_next.kind  = K_ALU_IMM;
                dec_next.imm   = imm_i;
            end
            OP_REG: begin
                dec_next.valid = (funct3 == F3_ADD) && (funct7 == F7_ADD);
                dec_next.kind  = K_ALU_REG;
            end
            OP_LOAD: begin
                dec_next.valid = (funct3 == F3_DW);      // ld
                dec_next.kind  = K_LOAD;
                dec_next.imm   = imm_i;
            end
            OP_STORE: begin
                dec_next.valid = (funct3 == F3_DW);      // sd
                dec_next.kind  = K_STORE;
                dec_next.imm   = imm_s;
                dec_next.rd    = '0;                     // rd bits are imm here
            end
            OP_SYSTEM: begin
                dec_next.valid = (instr[31:7] == {F12_MRET, 13'b0});
                dec_next.kind  = K_MRET;
                dec_next.rd    = '0;
            end
            default: dec_next.valid = 1'b0;
        endcase
    end

    // pc and decode register
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc  <= RESET_PC;
            dec <= '0;
        end else if (redirect) begin
            pc  <= redirect_pc;   // new target next edge
            dec <= '0;            // drop the word already fetched
        end else if (!stall) begin
            pc  <= pc + 64'd4;
            dec <= dec_next;
        end
    end

endmodule

//--- hdl/exec_core.sv
`timescale 1ns/1ps

module exec_core (
    input  logic                    clk,
    input  logic                    reset,
    input  rv_pkg::dec_t            dec,
    input  logic                    irq,
    output logic                    irq_ack,
    output logic                    stall,
    output logic                    redirect,
    output logic [rv_pkg::XLEN-1:0] redirect_pc,
    output rv_pkg::bus_req_t        mem_req,
    input  logic                    mem_done,
    input  logic [rv_pkg::XLEN-1:0] load_data,
    output rv_pkg::retire_t         retire
);
    import rv_pkg::*;

    typedef enum logic {
        S_IDLE,   // one instruction per cycle
        S_WAIT    // load/store out on the bus
    } state_t;

    state_t          state;
    logic [XLEN-1:0] regs [NREGS];
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
    logic [XLEN-1:0] alu_val;
    logic [XLEN-1:0] wr_val;
    logic [XLEN-1:0] mepc;
    logic            pending;     // inside the handler
    logic            is_mem;
    logic            take_irq;
    logic            do_alu;
    logic            do_mret;
    logic            mem_issue;
    logic            mem_finish;
    logic            wr_en;

    // operand read, x0 reads zero
    assign rs1_val = (dec.rs1 == '0) ? '0 : regs[dec.rs1];
    assign rs2_val = (dec.rs2 == '0) ? '0 : regs[dec.rs2];

    assign is_mem = (dec.kind == K_LOAD) || (dec.kind == K_STORE);

    // irq only between instructions, and not while a handler runs
    assign take_irq   = (state == S_IDLE) && dec.valid && irq && !pending;
    assign mem_issue  = (state == S_IDLE) && dec.valid && is_mem && !take_irq;
    assign do_mret    = (state == S_IDLE) && dec.valid && (dec.kind == K_MRET) && !take_irq;
    assign do_alu     = (state == S_IDLE) && dec.valid && !is_mem
                        && (dec.kind != K_MRET) && !take_irq;
    assign mem_finish = (state == S_WAIT) && mem_done;

    // alu, add only
    always_comb begin
        case (dec.kind)
            K_ALU_IMM: alu_val = rs1_val + dec.imm;
            K_ALU_REG: alu_val = rs1_val + rs2_val;
            K_LUI:     alu_val = dec.imm;
            default:   alu_val = '0;
        endcase
    end

    // register write back, alu result or load data
    assign wr_en  = (do_alu || (mem_finish && (dec.kind == K_LOAD))) && (dec.rd != '0);
    assign wr_val = mem_finish ? load_data : alu_val;

    // dec holds still until mem_done, so fetch waits
    assign stall = mem_issue || ((state == S_WAIT) && !mem_done);

    assign redirect    = take_irq || do_mret;
    assign redirect_pc = take_irq ? TRAP_VEC : mepc;

    // request to bus_port, valid for the issue cycle only
    always_comb begin
        mem_req       = '0;
        mem_req.addr  = rs1_val + dec.imm;   // rs1 + offset
        mem_req.wdata = rs2_val;
        mem_req.write = (dec.kind == K_STORE);
        mem_req.valid = mem_issue;
    end

    // control
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state   <= S_IDLE;
            pending <= 1'b0;
            irq_ack <= 1'b0;
            retire  <= '0;
        end else begin
            irq_ack      <= take_irq;   // single pulse
            retire.valid <= 1'b0;
            case (state)
                S_IDLE: if (mem_issue) state <= S_WAIT;
                S_WAIT: if (mem_done) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
            if (take_irq) begin
                pending <= 1'b1;
            end else if (do_mret) begin
                pending <= 1'b0;
            end
            if (do_alu || do_mret || mem_finish) begin
                retire.valid <= 1'b1;
                retire.pc    <= dec.pc;
                retire.rd    <= wr_en ? dec.rd : '0;   // stores, mret, x0 report zero
                retire.value <= wr_en ? wr_val : '0;
            end
        end
    end

    // register file, x0 never written
    always_ff @(posedge clk) begin
        if (wr_en) begin
            regs[dec.rd] <= wr_val;
        end
    end

    // interrupted instruction is re-run after mret
    always_ff @(posedge clk) begin
        if (take_irq) begin
            mepc <= dec.pc;
        end
    end

endmodule

//--- hdl/bus_port.sv
`timescale 1ns/1ps

module bus_port (
    input  logic                    clk,
    input  logic                    reset,
    input  rv_pkg::bus_req_t        mem_req,
    output logic                    mem_done,
    output logic [rv_pkg::XLEN-1:0] load_data,
    output rv_pkg::bus_req_t        bus_req,
    input  logic                    bus_ready,
    input  rv_pkg::bus_rsp_t        bus_rsp
);
    import rv_pkg::*;

    bus_req_t req_hold;   // address / data of the current op
    logic     req_vld;    // request on the bus, not yet taken
    logic     wait_rsp;   // read accepted, data not back
    logic     idle;
    logic     accept;

    assign idle   = !req_vld && !wait_rsp;   // one op at a time
    assign accept = req_vld && bus_ready;

    // payload, held while ready is low
    always_ff @(posedge clk) begin
        if (idle && mem_req.valid) begin
            req_hold <= mem_req;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            req_vld  <= 1'b0;
            wait_rsp <= 1'b0;
        end else begin
            if (idle && mem_req.valid) begin
                req_vld <= 1'b1;                    // on the bus next cycle
            end else if (accept) begin
                req_vld  <= 1'b0;
                wait_rsp <= !req_hold.write;        // reads wait for data
            end else if (wait_rsp && bus_rsp.valid) begin
                wait_rsp <= 1'b0;
            end
        end
    end

    always_comb begin
        bus_req       = req_hold;
        bus_req.valid = req_vld;
    end

    // store ends on acceptance, load on response
    assign mem_done  = (accept && req_hold.write) || (wait_rsp && bus_rsp.valid);
    assign load_data = bus_rsp.rdata;

endmodule

//--- hdl/rv_core_top.sv
`timescale 1ns/1ps

module rv_core_top (
    input  logic                    clk,
    input  logic                    reset,
    output logic [rv_pkg::XLEN-1:0] pc,
    input  logic [rv_pkg::ILEN-1:0] instr,      // combinational imem
    input  logic                    irq,        // level
    output logic                    irq_ack,
    output rv_pkg::bus_req_t        bus_req,
    input  logic                    bus_ready,
    input  rv_pkg::bus_rsp_t        bus_rsp,
    output rv_pkg::retire_t         retire
);
    import rv_pkg::*;

    dec_t            dec;
    logic            stall;
    logic            redirect;
    logic [XLEN-1:0] redirect_pc;
    bus_req_t        mem_req;
    logic            mem_done;
    logic [XLEN-1:0] load_data;

    // pc out, decode register
    fetch_stage u_fetch (
        .clk         (clk),
        .reset       (reset),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .instr       (instr),
        .pc          (pc),
        .dec         (dec)
    );

    // regfile, alu, load/store, irq
    exec_core u_exec (
        .clk         (clk),
        .reset       (reset),
        .dec         (dec),
        .irq         (irq),
        .irq_ack     (irq_ack),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .mem_req     (mem_req),
        .mem_done    (mem_done),
        .load_data   (load_data),
        .retire      (retire)
    );

    // peripheral side
    bus_port u_bus (
        .clk       (clk),
        .reset     (reset),
        .mem_req   (mem_req),
        .mem_done  (mem_done),
        .load_data (load_data),
        .bus_req   (bus_req),
        .bus_ready (bus_ready),
        .bus_rsp   (bus_rsp)
    );

endmodule

//--- tests/rv_core_chk.sv
`timescale 1ns/1ps

module rv_core_chk (
    input logic             clk,
    input logic             reset,
    input rv_pkg::bus_req_t bus_req,
    input logic             bus_ready,
    input logic             irq_ack,
    input logic             stall,
    input logic             redirect,
    input logic             dec_valid
);
    import rv_pkg::*;

    // request frozen under back-pressure
    req_hold: assert property (@(posedge clk) disable iff (!reset)
        (bus_req.valid && !bus_ready) |=> $stable(bus_req))
        else $error("bus request changed while waiting for ready");

    // ack only between instructions
    ack_no_stall: assert property (@(posedge clk) disable iff (!reset)
        $rose(irq_ack) |-> !stall)
        else $error("irq_ack rose during a stall");

    // bubble after redirect
    redirect_bubble: assert property (@(posedge clk) disable iff (!reset)
        redirect |=> !dec_valid)
        else $error("decode not emptied after redirect");

endmodule

//--- tests/rv_core_tb.sv
`timescale 1ns/1ps

`include "rv_map.svh"

// free running 10 ns clock
module clk_gen (
    output logic clk
);
    initial clk = 1'b0;
    always #5 clk = ~clk;
endmodule

module rv_core_tb;
    import rv_pkg::*;

    logic            clk;
    logic            reset;
    logic [XLEN-1:0] pc;
    logic [ILEN-1:0] instr;
    logic            irq;
    logic            irq_ack;
    bus_req_t        bus_req;
    logic            bus_ready;
    bus_rsp_t        bus_rsp;
    retire_t         retire;

    logic [63:0]     stim [0:255];   // 4 words per record
    logic [31:0]     imem [0:255];   // 1 KB at RAM_BASE
    logic [63:0]     exp_pc [$];
    logic [4:0]      exp_rd [$];
    logic [63:0]     exp_val [$];
    logic [63:0]     st_addr [$];
    logic [63:0]     st_data [$];
    logic [63:0]     key_q [$];      // key read data in read order
    logic [63:0]     imem_off;
    logic [31:0]     seed;
    logic [63:0]     rsp_data;
    logic            rsp_pend;
    int              rsp_cnt;
    int              req_age;        // cycles the current request has been on the bus
    int              n_ret;
    int              n_st;
    int              ret_idx;
    int              st_idx;
    int              n_reads;
    int              ack_cnt;
    int              ret_err;
    int              bus_err;
    int              other_err;
    int              cycles;
    int              limit;
    logic            after_ack;      // next retire must be the handler

    clk_gen clk0 (.clk(clk));

    rv_core_top dut0 (
        .clk       (clk),
        .reset     (reset),
        .pc        (pc),
        .instr     (instr),
        .irq       (irq),
        .irq_ack   (irq_ack),
        .bus_req   (bus_req),
        .bus_ready (bus_ready),
        .bus_rsp   (bus_rsp),
        .retire    (retire)
    );

    bind rv_core_top rv_core_chk chk0 (
        .clk       (clk),
        .reset     (reset),
        .bus_req   (bus_req),
        .bus_ready (bus_ready),
        .irq_ack   (irq_ack),
        .stall     (stall),
        .redirect  (redirect),
        .dec_valid (dec.valid)
    );

    // 32-bit lcg step
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // combinational imem where zero words decode invalid
    assign imem_off = pc - `RAM_BASE;
    assign instr    = (imem_off < 64'd1024) ? imem[imem_off[9:2]] : 32'h0;

    // retire checker in program order
    always @(posedge clk) begin
        if (reset && retire.valid) begin
            assert (ret_idx < n_ret) else begin
                other_err++;
                $display("unexpected retire at pc %h after the last expected one", retire.pc);
            end
            if (ret_idx < n_ret) begin
                assert (retire.pc == exp_pc[ret_idx]) else begin
                    ret_err++;
                    $display("FAILED retire %0d pc expected %h actual %h",
                             ret_idx, exp_pc[ret_idx], retire.pc);
                end
                assert (retire.rd == exp_rd[ret_idx]) else begin
                    ret_err++;
                    $display("FAILED retire %0d rd expected %0d actual %0d",
                             ret_idx, exp_rd[ret_idx], retire.rd);
                end
                assert (retire.value == exp_val[ret_idx]) else begin
                    ret_err++;
                    $display("FAILED retire %0d value expected %h actual %h",
                             ret_idx, exp_val[ret_idx], retire.value);
                end
                ret_idx++;
            end
            if (after_ack) begin
                assert (retire.pc == TRAP_VEC) else begin
                    other_err++;
                    $display("FAILED irq entry pc expected %h actual %h", TRAP_VEC, retire.pc);
                end
                after_ack = 1'b0;
            end
        end
    end

    // key and art peripheral model with random ready and response delay
    always @(posedge clk) begin
        if (reset) begin
            if (bus_req.valid && bus_ready) begin
                if (bus_req.write) begin
                    assert (st_idx < n_st) else begin
                        bus_err++;
                        $display("store to %h was not expected", bus_req.addr);
                    end
                    if (st_idx < n_st) begin
                        assert (bus_req.addr == st_addr[st_idx]) else begin
                            bus_err++;
                            $display("FAILED store %0d addr expected %h actual %h",
                                     st_idx, st_addr[st_idx], bus_req.addr);
                        end
                        assert (bus_req.wdata == st_data[st_idx]) else begin
                            bus_err++;
                            $display("FAILED store %0d data expected %h actual %h",
                                     st_idx, st_data[st_idx], bus_req.wdata);
                        end
                        st_idx++;
                    end
                end else begin
                    assert (bus_req.addr[63:12] == `KEY_BASE >> 12) else begin
                        bus_err++;
                        $display("FAILED key read page expected %h actual %h",
                                 `KEY_BASE >> 12, bus_req.addr >> 12);
                    end
                    rsp_data = (key_q.size() > 0) ? key_q.pop_front() : 64'hdead_beef;
                    seed     = lcg_next(seed);
                    rsp_cnt  = 1 + int'(seed[20:18]);   // 1..8 cycles
                    rsp_pend = 1'b1;
                    n_reads++;
                end
            end
            if (irq_ack) begin
                ack_cnt++;
                after_ack = 1'b1;
            end
        end
        #1;
        irq     = (n_reads >= 2) && (ack_cnt == 0);   // level from the second key read to the ack
        req_age = bus_req.valid ? req_age + 1 : 0;
        seed    = lcg_next(seed);
        // first cycle of every store sees back-pressure
        bus_ready = (seed[17:16] != 2'b00) && !(bus_req.write && req_age == 1);
        bus_rsp   = '0;
        if (rsp_pend) begin
            rsp_cnt--;
            if (rsp_cnt == 0) begin
                bus_rsp.valid = 1'b1;
                bus_rsp.rdata = rsp_data;
                rsp_pend      = 1'b0;
            end
        end
    end

    // watchdog
    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout after %0d cycles, %0d of %0d retires seen",
                     cycles, ret_idx, n_ret);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        int  i;
        logic done;
        reset     = 1'b0;
        irq       = 1'b0;
        bus_ready = 1'b0;
        bus_rsp   = '0;
        seed      = 32'd61412;
        rsp_pend  = 1'b0;
        rsp_cnt   = 0;
        req_age   = 0;
        rsp_data  = '0;
        after_ack = 1'b0;
        limit     = 1000;
        for (i = 0; i < 256; i++) begin
            imem[i] = 32'h0;
        end
        $readmemh("tests/core_stim.txt", stim);
        i    = 0;
        done = 1'b0;
        while (!done && i < 256) begin
            case (stim[i])
                64'd1: imem[(stim[i+1] - `RAM_BASE) >> 2] = stim[i+2][31:0];
                64'd2: key_q.push_back(stim[i+1]);
                64'd3: begin
                    exp_pc.push_back(stim[i+1]);
                    exp_rd.push_back(stim[i+2][4:0]);
                    exp_val.push_back(stim[i+3]);
                end
                64'd4: begin
                    st_addr.push_back(stim[i+1]);
                    st_data.push_back(stim[i+2]);
                end
                default: done = 1'b1;   // end marker
            endcase
            i += 4;
        end
        n_ret = exp_pc.size();
        n_st  = st_addr.size();
        limit = 40 * (n_ret + n_st) + 200;

        repeat (10) @(posedge clk);
        #1 reset = 1'b1;

        while (ret_idx < n_ret || st_idx < n_st) begin
            @(posedge clk);
        end
        repeat (5) @(posedge clk);   // catch stray retires

        assert (key_q.size() == 0) else begin
            other_err++;
            $display("key data left unread, %0d words", key_q.size());
        end
        assert (ack_cnt == 1) else begin
            other_err++;
            $display("FAILED irq_ack count expected 1 actual %0d", ack_cnt);
        end
        $display("errors: retire %0d bus %0d other %0d", ret_err, bus_err, other_err);
        if (ret_err + bus_err + other_err == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- tests/core_stim.txt
// kind a b c : 1 imem addr word 0, 2 key rdata 0 0, 0 ends
// 3 retire pc rd value, 4 store addr data 0
1 1000 123450B7 0
1 1004 67808113 0
1 1008 FFF00193 0
1 100C 00310233 0
1 1010 00208033 0
1 1014 100002B7 0
1 1018 10001337 0
1 101C 0002B383 0
1 1020 00438433 0
1 1024 00833423 0
1 1028 0102B483 0
1 102C 00148513 0
1 1030 014505B3 0
1 1034 00B33023 0
1 1200 00700A13 0
1 1204 30200073 0
2 0123456789ABCDEF 0 0
2 FEDCBA9876543210 0 0
3 1000 1 12345000
3 1004 2 12345678
3 1008 3 FFFFFFFFFFFFFFFF
3 100C 4 12345677
3 1010 0 0
3 1014 5 10000000
3 1018 6 10001000
3 101C 7 0123456789ABCDEF
3 1020 8 012345679BE02466
3 1024 0 0
3 1028 9 FEDCBA9876543210
3 1200 14 7
3 1204 0 0
3 102C A FEDCBA9876543211
3 1030 B FEDCBA9876543218
3 1034 0 0
4 10001008 012345679BE02466 0
4 10001000 FEDCBA9876543218 0
0 0 0 0

//--- compile.f
+incdir+include
hdl/rv_pkg.sv
hdl/fetch_stage.sv
hdl/exec_core.sv
hdl/bus_port.sv
hdl/rv_core_top.sv
tests/rv_core_chk.sv
tests/rv_core_tb.sv

//--- run.sh
#!/bin/bash
# build and run the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f compile.f --top-module rv_core_tb -o rv_core_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/rv_core_sim > sim.log 2>&1
status=$?
cat sim.log

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" sim.log; then
    exit 1
fi
exit 0
